// File: hw/newton_sqrt_top.sv
`timescale 1ns/1ps
`default_nettype none

module newton_sqrt_top (
	input  logic                clk,
	input  logic                arst_n,

	input  logic                in_valid,
	input  nr_fmt_pkg::rad_t    in_rad,
	output logic                in_ready,

	output logic                out_valid,
	output nr_fmt_pkg::root_t   out_root,
	input  logic                out_ready
);

	// link k feeds stage k, the last link goes outside
	logic              vld  [nr_ctrl_pkg::ITERATIONS+1];
	logic              rdy  [nr_ctrl_pkg::ITERATIONS+1];
	nr_fmt_pkg::root_t root [nr_ctrl_pkg::ITERATIONS+1];
	nr_fmt_pkg::rad_t  rad  [nr_ctrl_pkg::ITERATIONS];

	nr_seed i_seed (
		.clk        (clk),
		.arst_n     (arst_n),
		.in_valid   (in_valid),
		.in_rad     (in_rad),
		.in_ready   (in_ready),
		.seed_valid (vld[0]),
		.seed_rad   (rad[0]),
		.seed_root  (root[0]),
		.seed_ready (rdy[0])
	);

	for (genvar i = 0; i < nr_ctrl_pkg::ITERATIONS; i++) begin : g_stage
		if (i < nr_ctrl_pkg::ITERATIONS - 1) begin : g_mid
			nr_stage i_stage (
				.clk      (clk),
				.arst_n   (arst_n),
				.up_valid (vld[i]),
				.up_rad   (rad[i]),
				.up_root  (root[i]),
				.up_ready (rdy[i]),
				.dn_valid (vld[i+1]),
				.dn_rad   (rad[i+1]),
				.dn_root  (root[i+1]),
				.dn_ready (rdy[i+1])
			);
		end else begin : g_last
			// radicand is not needed past the final iteration
			nr_stage i_stage (
				.clk      (clk),
				.arst_n   (arst_n),
				.up_valid (vld[i]),
				.up_rad   (rad[i]),
				.up_root  (root[i]),
				.up_ready (rdy[i]),
				.dn_valid (vld[i+1]),
				.dn_rad   (),
				.dn_root  (root[i+1]),
				.dn_ready (rdy[i+1])
			);
		end
	end

	assign out_valid                        = vld[nr_ctrl_pkg::ITERATIONS];
	assign out_root                         = root[nr_ctrl_pkg::ITERATIONS];
	assign rdy[nr_ctrl_pkg::ITERATIONS]     = out_ready;

endmodule

`default_nettype wire

// File: hw/nr_ctrl_pkg.sv
`default_nettype none

package nr_ctrl_pkg;

	// Newton stages in the chain
	localparam int ITERATIONS = 4;

	// one quotient bit per step, quotient is as wide as the estimate
	localparam int DIV_STEPS = nr_fmt_pkg::ROOT_W;

	// accept, divide, register the average
	localparam int STAGE_LAT = DIV_STEPS + 2;

	// per-stage sequencing
	typedef enum logic [1:0] {
		STG_IDLE,
		STG_DIVIDE,
		STG_HOLD
	} stage_state_e;

	// divider sequencing
	typedef enum logic [1:0] {
		DIV_IDLE,
		DIV_RUN,
		DIV_DONE
	} div_state_e;

endpackage

`default_nettype wire

// File: hw/nr_divider.sv
`timescale 1ns/1ps
`default_nettype none

module nr_divider (
	input  logic                           clk,
	input  logic                           arst_n,

	input  logic                           start,
	input  logic [nr_fmt_pkg::DVD_W-1:0]   dividend,
	input  nr_fmt_pkg::root_t              divisor,

	output logic                           busy,
	output logic                           done,
	output nr_fmt_pkg::root_t              quotient
);

	typedef logic [$clog2(nr_ctrl_pkg::DIV_STEPS)-1:0] cnt_t;

	nr_ctrl_pkg::div_state_e         state_q;
	cnt_t                            cnt_q;

	// partial remainder, remaining low dividend bits, held divisor
	nr_fmt_pkg::root_t               rem_q;
	nr_fmt_pkg::root_t               low_q;
	nr_fmt_pkg::root_t               dvs_q;
	nr_fmt_pkg::root_t               quo_q;

	nr_fmt_pkg::root_t               step_rem;
	nr_fmt_pkg::root_t               step_dvs;
	logic                            step_bit;
	logic [nr_fmt_pkg::ROOT_W:0]     step_res;
	logic                            load;

	// one restoring step returning {quotient bit, new remainder}
	// a zero divisor never subtracts, so its quotient stays zero
	function automatic logic [nr_fmt_pkg::ROOT_W:0] div_step(
		input nr_fmt_pkg::root_t rem,
		input logic              bit_in,
		input nr_fmt_pkg::root_t dvs
	);
		logic [nr_fmt_pkg::ROOT_W:0] trial;
		logic [nr_fmt_pkg::ROOT_W:0] diff;

		trial = {rem, bit_in};
		diff  = trial - {1'b0, dvs};
		if (dvs != '0 && trial >= {1'b0, dvs}) begin
			div_step = {1'b1, diff[nr_fmt_pkg::ROOT_W-1:0]};
		end else begin
			div_step = {1'b0, trial[nr_fmt_pkg::ROOT_W-1:0]};
		end
	endfunction

	assign load = (state_q == nr_ctrl_pkg::DIV_IDLE) && start;

	// The upper dividend bits seed the remainder directly. They are always
	// below the divisor here, so a quotient of ROOT_W bits is enough.
	// The first step runs on the load edge itself.
	assign step_rem = load ?
		{{(2 * nr_fmt_pkg::ROOT_W - nr_fmt_pkg::DVD_W){1'b0}},
		 dividend[nr_fmt_pkg::DVD_W-1:nr_fmt_pkg::ROOT_W]} : rem_q;
	assign step_bit = load ? dividend[nr_fmt_pkg::ROOT_W-1] : low_q[nr_fmt_pkg::ROOT_W-1];
	assign step_dvs = load ? divisor : dvs_q;
	assign step_res = div_step(step_rem, step_bit, step_dvs);

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			state_q <= nr_ctrl_pkg::DIV_IDLE;
			cnt_q   <= '0;
		end else begin
			case (state_q)
				nr_ctrl_pkg::DIV_IDLE: begin
					if (start) begin
						state_q <= nr_ctrl_pkg::DIV_RUN;
						cnt_q   <= cnt_t'(nr_ctrl_pkg::DIV_STEPS - 2);
					end
				end
				nr_ctrl_pkg::DIV_RUN: begin
					if (cnt_q == '0) begin
						state_q <= nr_ctrl_pkg::DIV_DONE;
					end else begin
						cnt_q <= cnt_q - cnt_t'(1);
					end
				end
				nr_ctrl_pkg::DIV_DONE: begin
					state_q <= nr_ctrl_pkg::DIV_IDLE;
				end
				default: begin
					state_q <= nr_ctrl_pkg::DIV_IDLE;
				end
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (load) begin
			rem_q <= step_res[nr_fmt_pkg::ROOT_W-1:0];
			quo_q <= {{(nr_fmt_pkg::ROOT_W-1){1'b0}}, step_res[nr_fmt_pkg::ROOT_W]};
			low_q <= {dividend[nr_fmt_pkg::ROOT_W-2:0], 1'b0};
			dvs_q <= divisor;
		end else if (state_q == nr_ctrl_pkg::DIV_RUN) begin
			rem_q <= step_res[nr_fmt_pkg::ROOT_W-1:0];
			quo_q <= {quo_q[nr_fmt_pkg::ROOT_W-2:0], step_res[nr_fmt_pkg::ROOT_W]};
			low_q <= {low_q[nr_fmt_pkg::ROOT_W-2:0], 1'b0};
		end
	end

	// busy through the done cycle so a caller cannot restart early
	assign busy     = (state_q != nr_ctrl_pkg::DIV_IDLE);
	assign done     = (state_q == nr_ctrl_pkg::DIV_DONE);
	assign quotient = quo_q;

endmodule

`default_nettype wire

// File: hw/nr_fmt_pkg.sv
`default_nettype none

package nr_fmt_pkg;

	// radicand is a plain unsigned integer
	localparam int RAD_W = 16;

	// fraction bits of every estimate and of the result
	localparam int FRAC_W = 8;

	// Q9.8, one integer bit above a 16-bit root.
	// The seed of a radicand with bit 15 set is 256.0, which needs that bit.
	localparam int ROOT_W = 17;

	// radicand scaled up by two fraction widths
	// so that (b << 2F) / x comes out in Q.F
	localparam int DVD_W = RAD_W + 2 * FRAC_W;

	// one radicand word
	typedef logic [RAD_W-1:0] rad_t;

	// one estimate or result word
	typedef logic [ROOT_W-1:0] root_t;

endpackage

`default_nettype wire

// File: hw/nr_seed.sv
`timescale 1ns/1ps
`default_nettype none

module nr_seed (
	input  logic                clk,
	input  logic                arst_n,

	input  logic                in_valid,
	input  nr_fmt_pkg::rad_t    in_rad,
	output logic                in_ready,

	output logic                seed_valid,
	output nr_fmt_pkg::rad_t    seed_rad,
	output nr_fmt_pkg::root_t   seed_root,
	input  logic                seed_ready
);

	logic              valid_q;
	nr_fmt_pkg::rad_t  rad_q;
	nr_fmt_pkg::root_t root_q;
	nr_fmt_pkg::root_t seed_calc;
	logic              accept;

	// seed = 2^ceil((msb+1)/2), always at or above sqrt(b)
	// the highest set bit wins since it is written last
	always_comb begin
		seed_calc = '0;
		for (int i = 0; i < nr_fmt_pkg::RAD_W; i++) begin
			if (in_rad[i]) begin
				seed_calc = nr_fmt_pkg::root_t'(1) << ((i + 2) / 2 + nr_fmt_pkg::FRAC_W);
			end
		end
	end

	// one entry, free when empty or when it drains this cycle
	assign in_ready = !valid_q || seed_ready;
	assign accept   = in_valid && in_ready;

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			valid_q <= 1'b0;
		end else if (accept) begin
			valid_q <= 1'b1;
		end else if (seed_ready) begin
			valid_q <= 1'b0;
		end
	end

	always_ff @(posedge clk) begin
		if (accept) begin
			rad_q  <= in_rad;
			root_q <= seed_calc;
		end
	end

	assign seed_valid = valid_q;
	assign seed_rad   = rad_q;
	assign seed_root  = root_q;

endmodule

`default_nettype wire

// File: hw/nr_stage.sv
`timescale 1ns/1ps
`default_nettype none

module nr_stage (
	input  logic                clk,
	input  logic                arst_n,

	input  logic                up_valid,
	input  nr_fmt_pkg::rad_t    up_rad,
	input  nr_fmt_pkg::root_t   up_root,
	output logic                up_ready,

	output logic                dn_valid,
	output nr_fmt_pkg::rad_t    dn_rad,
	output nr_fmt_pkg::root_t   dn_root,
	input  logic                dn_ready
);

	nr_ctrl_pkg::stage_state_e          state_q;

	// operands held for the whole division, estimate replaced on done
	nr_fmt_pkg::rad_t                   rad_q;
	nr_fmt_pkg::root_t                  root_q;

	logic                               accept;
	logic                               div_start;
	logic [nr_fmt_pkg::DVD_W-1:0]       div_dividend;
	logic                               div_busy;
	logic                               div_done;
	nr_fmt_pkg::root_t                  div_quo;

	logic [nr_fmt_pkg::ROOT_W:0]        sum;
	nr_fmt_pkg::root_t                  avg;

	assign up_ready = (state_q == nr_ctrl_pkg::STG_IDLE) ||
	                  (state_q == nr_ctrl_pkg::STG_HOLD && dn_ready);
	assign accept   = up_valid && up_ready;

	// start once, in the first divide cycle
	assign div_start = (state_q == nr_ctrl_pkg::STG_DIVIDE) && !div_busy;

	// b << 2F over x in Q.F gives b / x in Q.F
	assign div_dividend = {rad_q, {(2 * nr_fmt_pkg::FRAC_W){1'b0}}};

	nr_divider i_div (
		.clk      (clk),
		.arst_n   (arst_n),
		.start    (div_start),
		.dividend (div_dividend),
		.divisor  (root_q),
		.busy     (div_busy),
		.done     (div_done),
		.quotient (div_quo)
	);

	// x' = (x + b/x) / 2, truncated
	assign sum = {1'b0, root_q} + {1'b0, div_quo};
	assign avg = sum[nr_fmt_pkg::ROOT_W:1];

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			state_q <= nr_ctrl_pkg::STG_IDLE;
		end else begin
			case (state_q)
				nr_ctrl_pkg::STG_IDLE: begin
					if (up_valid) begin
						state_q <= nr_ctrl_pkg::STG_DIVIDE;
					end
				end
				nr_ctrl_pkg::STG_DIVIDE: begin
					if (div_done) begin
						state_q <= nr_ctrl_pkg::STG_HOLD;
					end
				end
				nr_ctrl_pkg::STG_HOLD: begin
					// a new item may enter on the same edge the old one leaves
					if (dn_ready) begin
						if (up_valid) begin
							state_q <= nr_ctrl_pkg::STG_DIVIDE;
						end else begin
							state_q <= nr_ctrl_pkg::STG_IDLE;
						end
					end
				end
				default: begin
					state_q <= nr_ctrl_pkg::STG_IDLE;
				end
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (accept) begin
			rad_q  <= up_rad;
			root_q <= up_root;
		end else if (state_q == nr_ctrl_pkg::STG_DIVIDE && div_done) begin
			root_q <= avg;
		end
	end

	assign dn_valid = (state_q == nr_ctrl_pkg::STG_HOLD);
	assign dn_rad   = rad_q;
	assign dn_root  = root_q;

endmodule

`default_nettype wire

// File: newton_sqrt.f
+incdir+include
hw/nr_fmt_pkg.sv
hw/nr_ctrl_pkg.sv
hw/nr_seed.sv
hw/nr_divider.sv
hw/nr_stage.sv
hw/newton_sqrt_top.sv
sim/tb_newton_sqrt.sv

// File: run_sim.sh
#!/usr/bin/env bash
set -e

cd "$(dirname "$0")"

rm -rf obj_dir sim.log

verilator --binary --timing --assert \
	-f newton_sqrt.f \
	--top-module tb_newton_sqrt \
	-o sim_newton_sqrt

./obj_dir/sim_newton_sqrt | tee sim.log

if grep -q -F "** PASS **" sim.log; then
	echo "simulation passed"
	exit 0
else
	echo "simulation failed, see sim.log"
	exit 1
fi

// File: include/tb_sqrt_table.svh
`ifndef TB_SQRT_TABLE_SVH
`define TB_SQRT_TABLE_SVH

// columns: radicand in [23:8], out_ready pattern in [7:0]
// pattern bits replay LSB first, one per cycle, while the result is pending

localparam int TABLE_LEN = 20;

localparam logic [23:0] sqrt_table [TABLE_LEN] = '{
	{16'd0,     8'hff},
	{16'd1,     8'hff},
	{16'd2,     8'hfe},
	{16'd3,     8'hff},
	{16'd4,     8'h5a},
	{16'd9,     8'hff},
	{16'd15,    8'h0f},
	{16'd16,    8'hff},
	// around the first seed step of bit 8
	{16'd255,   8'ha5},
	{16'd256,   8'hff},
	{16'd1000,  8'hcc},
	{16'd4095,  8'hff},
	{16'd4096,  8'he7},
	{16'd16383, 8'h33},
	{16'd16384, 8'hff},
	{16'd32767, 8'h81},
	// bit 15 set, seed is 256.0
	{16'd32768, 8'hff},
	{16'd40000, 8'hf0},
	{16'd65534, 8'h69},
	{16'd65535, 8'hff}
};

`endif

// File: sim/tb_newton_sqrt.sv
`timescale 1ns/1ps
`default_nettype none

module tb_newton_sqrt;

	`include "tb_sqrt_table.svh"

	localparam int CLK_PERIOD = 20;
	localparam int RAND_COUNT = 40;
	localparam int LATENCY = 1 + nr_ctrl_pkg::ITERATIONS * nr_ctrl_pkg::STAGE_LAT;
	localparam int ITEMS = 1 + TABLE_LEN + 2 * RAND_COUNT;
	localparam int WATCHDOG_CYCLES = (ITEMS + 2) * LATENCY * 2;
	localparam logic [31:0] SEED = 32'h5be442e9;

	// out_ready modes
	localparam int MODE_HIGH = 0;
	localparam int MODE_PATTERN = 1;
	localparam int MODE_RANDOM = 2;

	logic              clk = 1'b0;
	logic              arst_n = 1'b0;
	logic              in_valid = 1'b0;
	nr_fmt_pkg::rad_t  in_rad = '0;
	logic              in_ready;
	logic              out_valid;
	nr_fmt_pkg::root_t out_root;
	logic              out_ready = 1'b1;

	int                ready_mode = MODE_HIGH;
	logic [7:0]        ready_pat = 8'hff;
	logic [2:0]        pat_pos = 3'd0;
	logic [31:0]       ready_rng = SEED;
	logic [31:0]       data_rng = SEED;

	// scoreboard
	nr_fmt_pkg::rad_t  exp_rad [$];
	time               acc_time [$];
	logic              held_valid = 1'b0;
	nr_fmt_pkg::root_t held_root = '0;
	int                last_latency = 0;
	int                results = 0;
	int                checks = 0;
	int                errors = 0;
	int                tests = 0;

	newton_sqrt_top i_dut (
		.clk       (clk),
		.arst_n    (arst_n),
		.in_valid  (in_valid),
		.in_rad    (in_rad),
		.in_ready  (in_ready),
		.out_valid (out_valid),
		.out_root  (out_root),
		.out_ready (out_ready)
	);

	function automatic logic [31:0] xorshift32(input logic [31:0] x);
		logic [31:0] y;
		y = x ^ (x << 13);
		y = y ^ (y >> 17);
		y = y ^ (y << 5);
		return y;
	endfunction

	// floor(sqrt(b) * 256) by bisection on the square
	function automatic longint ref_root(input nr_fmt_pkg::rad_t b);
		longint target;
		longint lo;
		longint hi;
		longint mid;
		target = longint'(b) << (2 * nr_fmt_pkg::FRAC_W);
		lo = 0;
		hi = longint'(1) << nr_fmt_pkg::ROOT_W;
		while (hi - lo > 1) begin
			mid = (lo + hi) / 2;
			if (mid * mid <= target) begin
				lo = mid;
			end else begin
				hi = mid;
			end
		end
		return lo;
	endfunction

	task automatic check_root(input nr_fmt_pkg::rad_t b, input nr_fmt_pkg::root_t got);
		longint expected;
		longint diff;
		expected = ref_root(b);
		diff = longint'(got) - expected;
		checks++;
		if (b == '0) begin
			assert (got == '0) else begin
				errors++;
				$display("ERROR t=%0d ns out_root: got %0d expected 0 for radicand 0", $time, got);
			end
		end else begin
			assert (diff <= 2 && diff >= -2) else begin
				errors++;
				$display("ERROR t=%0d ns out_root: got %0d expected %0d for radicand %0d",
					$time, got, expected, b);
			end
		end
	endtask

	task automatic check_count(input int sent, input int got);
		checks++;
		assert (sent == got) else begin
			errors++;
			$display("%0d radicands were sent but %0d results came back", sent, got);
		end
	endtask

	// called on a rising edge and returns on the transfer edge
	task automatic send_item(input nr_fmt_pkg::rad_t rad);
		in_valid <= 1'b1;
		in_rad   <= rad;
		forever begin
			@(posedge clk);
			if (in_ready) begin
				break;
			end
		end
		exp_rad.push_back(rad);
		acc_time.push_back($time);
	endtask

	task automatic wait_drain();
		while (exp_rad.size() != 0) begin
			@(posedge clk);
		end
		repeat (4) @(posedge clk);
	endtask

	task automatic finish_test(input string name, input int err_before);
		tests++;
		$display("test %s finished with %0d mismatches", name, errors - err_before);
	endtask

	initial begin
		forever #(CLK_PERIOD / 2) clk = ~clk;
	end

	always @(posedge clk) begin
		case (ready_mode)
			MODE_PATTERN: begin
				// pattern restarts at bit 0 for every result
				if (out_valid) begin
					out_ready <= ready_pat[pat_pos];
					pat_pos   <= pat_pos + 3'd1;
				end else begin
					out_ready <= ready_pat[0];
					pat_pos   <= 3'd1;
				end
			end
			MODE_RANDOM: begin
				ready_rng = xorshift32(ready_rng);
				out_ready <= (ready_rng[1:0] != 2'b00);
			end
			default: begin
				out_ready <= 1'b1;
			end
		endcase
	end

	// output monitor sees the values that were present at the edge
	always @(posedge clk) begin
		nr_fmt_pkg::rad_t b;
		time t_acc;
		if (arst_n) begin
			if (held_valid) begin
				checks++;
				assert (out_valid && out_root == held_root) else begin
					errors++;
					if (!out_valid) begin
						$display("out_valid dropped at %0d ns before the result was taken", $time);
					end else begin
						$display("ERROR t=%0d ns out_root: got %0d expected %0d while stalled",
							$time, out_root, held_root);
					end
				end
			end
			held_valid = out_valid && !out_ready;
			held_root  = out_root;
			if (out_valid && out_ready) begin
				checks++;
				results++;
				assert (exp_rad.size() != 0) else begin
					errors++;
					$display("a result appeared at %0d ns with no radicand pending", $time);
				end
				if (exp_rad.size() != 0) begin
					b = exp_rad.pop_front();
					t_acc = acc_time.pop_front();
					last_latency = int'(($time - t_acc) / longint'(CLK_PERIOD));
					check_root(b, out_root);
				end
			end
		end
	end

	initial begin
		repeat (WATCHDOG_CYCLES) @(posedge clk);
		$display("watchdog expired after %0d cycles with %0d results still pending",
			WATCHDOG_CYCLES, exp_rad.size());
		$display("** FAIL **");
		$finish;
	end

	initial begin : main
		int err_before;
		int res_before;
		logic [23:0] entry;

		repeat (8) @(posedge clk);
		arst_n <= 1'b1;
		@(posedge clk);

		err_before = errors;
		checks += 2;
		assert (!out_valid) else begin
			errors++;
			$display("ERROR t=%0d ns out_valid: got %0b expected 0", $time, out_valid);
		end
		assert (in_ready) else begin
			errors++;
			$display("ERROR t=%0d ns in_ready: got %0b expected 1", $time, in_ready);
		end
		finish_test("reset", err_before);

		err_before = errors;
		send_item(16'd1000);
		in_valid <= 1'b0;
		wait_drain();
		checks++;
		assert (last_latency == LATENCY) else begin
			errors++;
			$display("ERROR t=%0d ns latency: got %0d expected %0d", $time, last_latency, LATENCY);
		end
		finish_test("latency", err_before);

		err_before = errors;
		ready_mode <= MODE_PATTERN;
		for (int i = 0; i < TABLE_LEN; i++) begin
			entry = sqrt_table[i];
			ready_pat <= entry[7:0];
			send_item(entry[23:8]);
			in_valid <= 1'b0;
			wait_drain();
		end
		ready_mode <= MODE_HIGH;
		finish_test("table", err_before);

		// back to back, no stalls
		err_before = errors;
		res_before = results;
		for (int n = 0; n < RAND_COUNT; n++) begin
			data_rng = xorshift32(data_rng);
			send_item(data_rng[15:0]);
		end
		in_valid <= 1'b0;
		wait_drain();
		check_count(RAND_COUNT, results - res_before);
		finish_test("stream", err_before);

		err_before = errors;
		res_before = results;
		ready_mode <= MODE_RANDOM;
		for (int n = 0; n < RAND_COUNT; n++) begin
			data_rng = xorshift32(data_rng);
			send_item(data_rng[15:0]);
		end
		in_valid <= 1'b0;
		wait_drain();
		ready_mode <= MODE_HIGH;
		check_count(RAND_COUNT, results - res_before);
		finish_test("backpressure", err_before);

		$display("tests=%0d checks=%0d errors=%0d", tests, checks, errors);
		if (errors == 0) begin
			$display("** PASS **");
		end else begin
			$display("** FAIL **");
		end
		$finish;
	end

endmodule

`default_nettype wire
